//--- logic/mandel_pkg.sv
package mandel_pkg;

    // ******************************
    // fixed-point format
    // ******************************
    localparam int INT_BITS   = 4;     // sign plus integer bits of z and c.
    localparam int SCALE_W    = 2;     // scale step select, four steps.

    // ******************************
    // configuration port
    // ******************************
    localparam int CFG_DATA_W = 16;    // register write data, low bits used.

    typedef enum logic [2:0] {
        ADDR_MAX_CTR    = 3'd0,        // iteration limit.
        ADDR_CTR_SELECT = 3'd1,        // colour window.
        ADDR_SCALING    = 3'd2,        // scale step.
        ADDR_CR_OFFSET  = 3'd3,        // real offset of pixel (0,0).
        ADDR_CI_OFFSET  = 3'd4,        // imaginary offset of pixel (0,0).
        ADDR_START      = 3'd5         // any write starts a frame.
    } cfg_addr_e;

    // ******************************
    // pixel colour
    // ******************************
    localparam int COLOR_W    = 4;

    // which 4-bit slice of the escape count becomes the colour
    typedef enum logic [1:0] {
        WIN_0 = 2'd0,                  // count bits 3..0.
        WIN_1 = 2'd1,                  // count bits 4..1.
        WIN_2 = 2'd2,                  // count bits 5..2.
        WIN_3 = 2'd3                   // count bits 6..3.
    } ctr_select_e;

endpackage

//--- logic/mandel_alu.sv
`timescale 1ns/1ps

module mandel_alu
    import mandel_pkg::*;
#(
    parameter int BITWIDTH = 10
) (
    input  logic signed [BITWIDTH-1:0] in_cr,
    input  logic signed [BITWIDTH-1:0] in_ci,
    input  logic signed [BITWIDTH-1:0] in_zr,
    input  logic signed [BITWIDTH-1:0] in_zi,
    output logic signed [BITWIDTH-1:0] out_zr,
    output logic signed [BITWIDTH-1:0] out_zi,
    output logic                       size,
    output logic                       overflow
);
    localparam int FRAC  = BITWIDTH - INT_BITS;       // fraction bits.
    localparam int PW    = 2 * BITWIDTH;              // full product width.
    localparam int SW    = PW + 2;                    // sums with headroom.
    localparam int FOUR  = 4 << FRAC;                 // escape radius squared.
    localparam int MAX_V = (1 << (BITWIDTH - 1)) - 1;
    localparam int MIN_V = -(1 << (BITWIDTH - 1));

    logic signed [PW-1:0] p_rr;
    logic signed [PW-1:0] p_ii;
    logic signed [PW-1:0] p_ri;
    logic signed [SW-1:0] sq_r;
    logic signed [SW-1:0] sq_i;
    logic signed [SW-1:0] sq_ri;
    logic signed [SW-1:0] sum_r;
    logic signed [SW-1:0] sum_i;
    logic signed [SW-1:0] mag;

    // ******************************
    // products, back to the z format
    // ******************************
    assign p_rr  = in_zr * in_zr;
    assign p_ii  = in_zi * in_zi;
    assign p_ri  = in_zr * in_zi;

    assign sq_r  = p_rr >>> FRAC;                     // zr^2.
    assign sq_i  = p_ii >>> FRAC;                     // zi^2.
    assign sq_ri = p_ri >>> FRAC;                     // zr*zi, doubled below.

    // ******************************
    // next z and escape test
    // ******************************
    assign sum_r = sq_r - sq_i + in_cr;
    assign sum_i = (sq_ri <<< 1) + in_ci;
    assign mag   = sq_r + sq_i;

    assign size  = (mag >= FOUR);

    // a component that leaves the signed range wraps, so flag it
    assign overflow = (sum_r > MAX_V) || (sum_r < MIN_V) ||
                      (sum_i > MAX_V) || (sum_i < MIN_V);

    assign out_zr = sum_r[BITWIDTH-1:0];
    assign out_zi = sum_i[BITWIDTH-1:0];

endmodule

//--- logic/mandel_engine.sv
`timescale 1ns/1ps

module mandel_engine
    import mandel_pkg::*;
#(
    parameter int BITWIDTH  = 10,
    parameter int CTRWIDTH  = 7,
    parameter int WIDTH     = 320,
    parameter int HEIGHT    = 240,
    localparam int X_W      = $clog2(WIDTH),
    localparam int Y_W      = $clog2(HEIGHT)
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       frame_start,
    input  logic [CTRWIDTH-1:0]        max_ctr,
    input  ctr_select_e                ctr_select,
    input  logic [SCALE_W-1:0]         scaling,
    input  logic signed [BITWIDTH-1:0] cr_offset,
    input  logic signed [BITWIDTH-1:0] ci_offset,
    input  logic                       has_credit,
    output logic                       busy,
    output logic                       result_valid,
    output logic [COLOR_W-1:0]         result_color,
    output logic [X_W-1:0]             result_x,
    output logic [Y_W-1:0]             result_y
);
    logic signed [BITWIDTH-1:0] zr;
    logic signed [BITWIDTH-1:0] zi;
    logic signed [BITWIDTH-1:0] cr;
    logic signed [BITWIDTH-1:0] ci;
    logic signed [BITWIDTH-1:0] out_zr;
    logic signed [BITWIDTH-1:0] out_zi;
    logic                       size;
    logic                       overflow;
    logic                       overflowed;
    logic [CTRWIDTH-1:0]        ctr;
    logic [X_W-1:0]             x;
    logic [Y_W-1:0]             y;
    logic [SCALE_W:0]           step;
    logic [BITWIDTH-1:0]        x_term;
    logic [BITWIDTH-1:0]        y_term;
    logic                       done;
    logic                       last_pixel;

    // ******************************
    // pixel to complex point
    // ******************************
    assign step   = scaling + 1'b1;                  // scale step 1..4.
    assign x_term = step * x;
    assign y_term = step * y;
    assign cr     = cr_offset + signed'(x_term);
    assign ci     = ci_offset + signed'(y_term);

    mandel_alu #(
        .BITWIDTH (BITWIDTH)
    ) alu (
        .in_cr    (cr),
        .in_ci    (ci),
        .in_zr    (zr),
        .in_zi    (zi),
        .out_zr   (out_zr),
        .out_zi   (out_zi),
        .size     (size),
        .overflow (overflow)
    );

    // ******************************
    // decision and output
    // ******************************
    // overflow is registered, so it ends the pixel one iteration late
    assign done         = size || overflowed || (ctr == max_ctr);
    assign last_pixel   = (x == WIDTH - 1) && (y == HEIGHT - 1);
    assign result_valid = busy && done && has_credit;
    assign result_x     = x;
    assign result_y     = y;

    // counter is frozen while stalled, so the colour holds.
    always_comb begin
        case (ctr_select)
            WIN_0:   result_color = ctr[0 +: COLOR_W];
            WIN_1:   result_color = ctr[1 +: COLOR_W];
            WIN_2:   result_color = ctr[2 +: COLOR_W];
            default: result_color = ctr[3 +: COLOR_W];
        endcase
    end

    // ******************************
    // sequencing and scan position
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            ctr        <= '0;
            overflowed <= 1'b0;
            x          <= '0;
            y          <= '0;
        end else if (frame_start) begin
            busy       <= 1'b1;                      // pixel (0,0) iterates next.
            ctr        <= '0;
            overflowed <= 1'b0;
            x          <= '0;
            y          <= '0;
        end else if (busy && !done) begin
            ctr        <= ctr + 1'b1;                // one iteration.
            overflowed <= overflow;
        end else if (result_valid) begin
            ctr        <= '0;
            overflowed <= 1'b0;
            if (last_pixel) begin
                busy <= 1'b0;
            end
            if (x == WIDTH - 1) begin
                x <= '0;
                y <= (y == HEIGHT - 1) ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start || result_valid) begin
            zr <= '0;                                // fresh pixel.
            zi <= '0;
        end else if (busy && !done) begin
            zr <= out_zr;
            zi <= out_zi;
        end
    end

    // a pixel waiting for a credit keeps its count and z
    a_stall_frozen: assert property (@(posedge clk) disable iff (reset)
        busy && done && !has_credit |=> $stable(ctr) && $stable(zr) && $stable(zi));

    a_x_in_frame: assert property (@(posedge clk) disable iff (reset)
        x < WIDTH);

endmodule

//--- logic/mandel_config.sv
`timescale 1ns/1ps

module mandel_config
    import mandel_pkg::*;
#(
    parameter int CTRWIDTH = 7,
    parameter int BITWIDTH = 10
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cfg_we,
    input  cfg_addr_e                  cfg_addr,
    input  logic [CFG_DATA_W-1:0]      cfg_wdata,
    input  logic                       busy,
    output logic [CTRWIDTH-1:0]        max_ctr,
    output ctr_select_e                ctr_select,
    output logic [SCALE_W-1:0]         scaling,
    output logic signed [BITWIDTH-1:0] cr_offset,
    output logic signed [BITWIDTH-1:0] ci_offset,
    output logic                       frame_start,
    output logic                       cfg_err
);
    localparam int ONE     = 1 << (BITWIDTH - INT_BITS);   // 1.0 in alu format.
    localparam int CR_INIT = -(5 * ONE) / 2;               // -2.5.
    localparam int CI_INIT = -(15 * ONE) / 8;              // -1.875.

    logic locked;
    logic accept;

    // a start already issued counts as busy, so no second one slips in
    assign locked = busy || frame_start;
    assign accept = cfg_we && !locked;

    always_ff @(posedge clk) begin
        if (reset) begin
            max_ctr     <= '1;
            ctr_select  <= WIN_0;
            scaling     <= '0;
            cr_offset   <= BITWIDTH'(CR_INIT);
            ci_offset   <= BITWIDTH'(CI_INIT);
            frame_start <= 1'b0;
            cfg_err     <= 1'b0;
        end else begin
            frame_start <= accept && (cfg_addr == ADDR_START);
            cfg_err     <= cfg_we && locked;       // rejected write.
            if (accept) begin
                case (cfg_addr)
                    ADDR_MAX_CTR:    max_ctr    <= cfg_wdata[CTRWIDTH-1:0];
                    ADDR_CTR_SELECT: ctr_select <= ctr_select_e'(cfg_wdata[1:0]);
                    ADDR_SCALING:    scaling    <= cfg_wdata[SCALE_W-1:0];
                    ADDR_CR_OFFSET:  cr_offset  <= cfg_wdata[BITWIDTH-1:0];
                    ADDR_CI_OFFSET:  ci_offset  <= cfg_wdata[BITWIDTH-1:0];
                    default: ;                     // start handled above.
                endcase
            end
        end
    end

    // the engine must be idle whenever a frame is started
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        frame_start |-> !busy);

endmodule

//--- logic/pixel_credit_out.sv
`timescale 1ns/1ps

module pixel_credit_out
    import mandel_pkg::*;
#(
    parameter int CREDITS  = 4,
    parameter int WIDTH    = 320,
    parameter int HEIGHT   = 240,
    localparam int X_W     = $clog2(WIDTH),
    localparam int Y_W     = $clog2(HEIGHT),
    localparam int CNT_W   = $clog2(CREDITS + 1)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               result_valid,
    input  logic [COLOR_W-1:0] result_color,
    input  logic [X_W-1:0]     result_x,
    input  logic [Y_W-1:0]     result_y,
    input  logic               credit_return,
    output logic               has_credit,
    output logic               pix_valid,
    output logic [COLOR_W-1:0] pix_color,
    output logic [X_W-1:0]     pix_x,
    output logic [Y_W-1:0]     pix_y
);
    logic [CNT_W-1:0] count;                       // credits held.

    // a pixel in the output register has already spent its credit.
    assign has_credit = (count > CNT_W'(pix_valid));

    // ******************************
    // credit counter
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CNT_W'(CREDITS);
        end else if (pix_valid && !credit_return) begin
            count <= count - 1'b1;
        end else if (credit_return && !pix_valid) begin
            count <= count + 1'b1;
        end
    end

    // ******************************
    // output register
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= result_valid;             // one cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid) begin
            pix_color <= result_color;
            pix_x     <= result_x;
            pix_y     <= result_y;
        end
    end

    // the sink never returns more than it was given
    a_count_max: assert property (@(posedge clk) disable iff (reset)
        count <= CREDITS);

    a_count_min: assert property (@(posedge clk) disable iff (reset)
        pix_valid && !credit_return |-> count != 0);

endmodule

//--- logic/mandel_top.sv
`timescale 1ns/1ps

module mandel_top
    import mandel_pkg::*;
#(
    parameter int BITWIDTH  = 10,
    parameter int CTRWIDTH  = 7,
    parameter int WIDTH     = 320,
    parameter int HEIGHT    = 240,
    parameter int CREDITS   = 4,
    localparam int X_W      = $clog2(WIDTH),
    localparam int Y_W      = $clog2(HEIGHT)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_we,
    input  cfg_addr_e             cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_wdata,
    output logic                  cfg_err,
    output logic                  busy,
    output logic                  pix_valid,
    output logic [COLOR_W-1:0]    pix_color,
    output logic [X_W-1:0]        pix_x,
    output logic [Y_W-1:0]        pix_y,
    input  logic                  credit_return
);
    logic [CTRWIDTH-1:0]        max_ctr;
    ctr_select_e                ctr_select;
    logic [SCALE_W-1:0]         scaling;
    logic signed [BITWIDTH-1:0] cr_offset;
    logic signed [BITWIDTH-1:0] ci_offset;
    logic                       frame_start;
    logic                       has_credit;
    logic                       result_valid;
    logic [COLOR_W-1:0]         result_color;
    logic [X_W-1:0]             result_x;
    logic [Y_W-1:0]             result_y;

    mandel_config #(.CTRWIDTH(CTRWIDTH), .BITWIDTH(BITWIDTH)) config_regs (
        .clk, .reset, .cfg_we, .cfg_addr, .cfg_wdata, .busy,
        .max_ctr, .ctr_select, .scaling, .cr_offset, .ci_offset,
        .frame_start, .cfg_err
    );

    mandel_engine #(
        .BITWIDTH(BITWIDTH), .CTRWIDTH(CTRWIDTH), .WIDTH(WIDTH), .HEIGHT(HEIGHT)
    ) engine (
        .clk, .reset, .frame_start, .max_ctr, .ctr_select, .scaling,
        .cr_offset, .ci_offset, .has_credit, .busy, .result_valid,
        .result_color, .result_x, .result_y
    );

    pixel_credit_out #(.CREDITS(CREDITS), .WIDTH(WIDTH), .HEIGHT(HEIGHT)) out_port (
        .clk, .reset, .result_valid, .result_color, .result_x, .result_y,
        .credit_return, .has_credit, .pix_valid, .pix_color, .pix_x, .pix_y
    );

endmodule

//--- sim/mandel_ref.svh
`ifndef MANDEL_REF_SVH
`define MANDEL_REF_SVH

// ******************************
// pixel model, FRAC fraction bits
// ******************************

// keep the low BITWIDTH bits and read them back as signed.
function automatic longint wrap_to_width(input longint v);
    longint m;
    m = v & ((longint'(1) << BITWIDTH) - 1);
    if (m >= (longint'(1) << (BITWIDTH - 1))) begin
        m = m - (longint'(1) << BITWIDTH);
    end
    return m;
endfunction

// iterations of z = z^2 + c until |z|^2 >= 4, a late overflow, or the limit
function automatic int escape_count(input longint cr, input longint ci, input int limit);
    longint zr;
    longint zi;
    longint rr;
    longint ii;
    longint next_r;
    longint next_i;
    bit     ovf;
    zr  = 0;
    zi  = 0;
    ovf = 1'b0;
    for (int n = 0; n < limit; n++) begin
        rr = (zr * zr) >>> FRAC;
        ii = (zi * zi) >>> FRAC;
        if ((rr + ii >= (4 << FRAC)) || ovf) begin
            return n;
        end
        next_r = rr - ii + cr;
        next_i = 2 * ((zr * zi) >>> FRAC) + ci;              // product scaled, then doubled.
        ovf    = (wrap_to_width(next_r) != next_r) || (wrap_to_width(next_i) != next_i);
        zr     = wrap_to_width(next_r);
        zi     = wrap_to_width(next_i);
    end
    return limit;
endfunction

// colour of pixel (x,y) for one set of frame settings.
function automatic int pixel_color(input int x, input int y, input int limit, input int window,
                                   input int scale, input int cr_off, input int ci_off);
    longint cr;
    longint ci;
    cr = wrap_to_width(cr_off + (scale + 1) * x);
    ci = wrap_to_width(ci_off + (scale + 1) * y);
    return (escape_count(cr, ci, limit) >> window) & 'hf;  // 4-bit window.
endfunction

`endif

//--- sim/mandel_tb.sv
`timescale 1ns/1ps

module mandel_tb
    import mandel_pkg::*;
();
    localparam int BITWIDTH = 10;
    localparam int CTRWIDTH = 7;
    localparam int WIDTH    = 8;
    localparam int HEIGHT   = 6;
    localparam int CREDITS  = 4;
    localparam int FRAC     = BITWIDTH - 4;
    localparam int TOTAL    = WIDTH * HEIGHT;
    localparam int FRAMES   = 9;
    localparam int LIMIT    = FRAMES * TOTAL * (127 + 3) * 4 + 1000;  // stalls, then setup.

    logic                  clk;
    logic                  reset;
    logic                  cfg_we;
    cfg_addr_e             cfg_addr;
    logic [CFG_DATA_W-1:0] cfg_wdata;
    logic                  cfg_err;
    logic                  busy;
    logic                  pix_valid;
    logic [COLOR_W-1:0]    pix_color;
    logic [2:0]            pix_x;
    logic [2:0]            pix_y;
    logic                  credit_return;

    int          got, held, pixels_seen, value_errors, other_errors, cycles;
    bit          frame_active, frame_done, sparse, keep, against_saved;
    logic [15:0] lfsr = 16'h0001;
    int          saved[TOTAL];
    // settings as the DUT should hold them, reset values first
    int          cur_max = 127, cur_sel = 0, cur_scale = 0, cur_cr = -160, cur_ci = -120;

    `include "mandel_ref.svh"

    mandel_top #(
        .BITWIDTH(BITWIDTH), .CTRWIDTH(CTRWIDTH), .WIDTH(WIDTH), .HEIGHT(HEIGHT),
        .CREDITS(CREDITS)
    ) uut (.*);

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // taps 16,14,13,11.
    endfunction

    task automatic report_mismatch(input string msg);
        value_errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        other_errors++;
        $display("at %0t ns %s", $time, msg);
    endtask

    task automatic print_counts();
        $display("pixels %0d, value errors %0d, other errors %0d",
                 pixels_seen, value_errors, other_errors);
    endtask

    // ******************************
    // configuration writes
    // ******************************
    task automatic write_reg(input cfg_addr_e addr, input int value, output logic err);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = CFG_DATA_W'(value);
        @(negedge clk);
        cfg_we    = 1'b0;
        err       = cfg_err;                               // one edge after the write.
    endtask

    task automatic set_reg(input cfg_addr_e addr, input int value);
        logic err;
        write_reg(addr, value, err);
        assert (!err) else report_mismatch($sformatf("cfg_err on idle write to %s", addr.name()));
        case (addr)
            ADDR_MAX_CTR:    cur_max   = value;
            ADDR_CTR_SELECT: cur_sel   = value;
            ADDR_SCALING:    cur_scale = value;
            ADDR_CR_OFFSET:  cur_cr    = value;
            ADDR_CI_OFFSET:  cur_ci    = value;
            default: ;
        endcase
    endtask

    task automatic write_locked(input cfg_addr_e addr, input int value);
        logic err;
        write_reg(addr, value, err);
        assert (err) else report_mismatch($sformatf("no cfg_err on busy write to %s", addr.name()));
    endtask

    task automatic start_frame(input bit sparse_return, input bit save_colors, input bit use_saved);
        sparse        = sparse_return;
        keep          = save_colors;
        against_saved = use_saved;
        got           = 0;
        frame_done    = 1'b0;
        frame_active  = 1'b1;
        set_reg(ADDR_START, 0);
    endtask

    task automatic run_frame(input bit sparse_return, input bit save_colors, input bit use_saved);
        start_frame(sparse_return, save_colors, use_saved);
        wait (frame_done);
    endtask

    // ******************************
    // pixel monitor and credit sink
    // ******************************
    task automatic check_pixel();
        int exp_x;
        int exp_y;
        int exp_color;
        if (!frame_active || got >= TOTAL) begin
            note_failure("a pixel arrived outside a frame or beyond the frame size");
        end else begin
            exp_x     = got % WIDTH;                       // raster order.
            exp_y     = got / WIDTH;
            exp_color = pixel_color(exp_x, exp_y, cur_max, cur_sel, cur_scale, cur_cr, cur_ci);
            assert (pix_x == exp_x && pix_y == exp_y) else report_mismatch($sformatf(
                "pixel %0d at (%0d,%0d), expected (%0d,%0d)", got, pix_x, pix_y, exp_x, exp_y));
            assert (pix_color == exp_color) else report_mismatch($sformatf(
                "pixel (%0d,%0d) colour %0d, expected %0d", exp_x, exp_y, pix_color, exp_color));
            if (against_saved) begin
                assert (pix_color == saved[got]) else report_mismatch($sformatf(
                    "pixel %0d colour %0d, unstalled frame gave %0d", got, pix_color, saved[got]));
            end
            if (keep) begin
                saved[got] = pix_color;
            end
            assert (busy == (got != TOTAL - 1)) else
                report_mismatch($sformatf("busy is %0b at pixel %0d", busy, got));
        end
        got++;
        held++;
        pixels_seen++;
        assert (held <= CREDITS) else note_failure("the sink holds more pixels than its credits");
    endtask

    always @(negedge clk) begin
        bit give;
        if (reset) begin
            held          = 0;
            credit_return = 1'b0;
        end else begin
            if (pix_valid) begin
                check_pixel();
            end
            give = (held > 0);                             // only credits it holds.
            if (give && sparse) begin
                lfsr = lfsr_step(lfsr);
                give = lfsr[0];
                lfsr = lfsr_step(lfsr);
                give = give && lfsr[0];                    // about one in four.
            end
            credit_return = give;
            held          = held - give;
            if (frame_active && got == TOTAL && held == 0 && !busy) begin
                frame_active = 1'b0;
                frame_done   = 1'b1;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        note_failure($sformatf("timed out after %0d cycles, a frame never finished", cycles));
        print_counts();
        $display("tests failed");
        $finish;
    end

    // ******************************
    // test sequence
    // ******************************
    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        cfg_we        = 1'b0;
        cfg_addr      = ADDR_MAX_CTR;
        cfg_wdata     = '0;
        credit_return = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (10) begin
            @(negedge clk);
            assert (!busy && !pix_valid) else report_mismatch("busy or pix_valid high after reset");
        end

        run_frame(1'b0, 1'b0, 1'b0);                       // reset settings.
        set_reg(ADDR_CR_OFFSET, -96);                      // -1.5.
        set_reg(ADDR_CI_OFFSET, -32);                      // -0.5.
        set_reg(ADDR_SCALING, 3);
        run_frame(1'b0, 1'b1, 1'b0);                       // kept for the stalled runs.
        for (int w = 1; w < 4; w++) begin
            set_reg(ADDR_CTR_SELECT, w);
            run_frame(1'b0, 1'b0, 1'b0);
        end
        set_reg(ADDR_SCALING, 1);
        run_frame(1'b0, 1'b0, 1'b0);
        set_reg(ADDR_MAX_CTR, 9);
        set_reg(ADDR_CTR_SELECT, WIN_0);
        run_frame(1'b0, 1'b0, 1'b0);

        // back to the kept frame, now with sparse credits
        set_reg(ADDR_MAX_CTR, 127);
        set_reg(ADDR_SCALING, 3);
        run_frame(1'b1, 1'b0, 1'b1);

        start_frame(1'b1, 1'b0, 1'b1);
        wait (busy);
        write_locked(ADDR_MAX_CTR, 3);
        write_locked(ADDR_CR_OFFSET, 0);
        write_locked(ADDR_CTR_SELECT, WIN_3);
        write_locked(ADDR_START, 0);
        wait (frame_done);
        repeat (30) begin
            @(negedge clk);
            assert (!busy && !pix_valid) else
                note_failure("a start written while busy began a second frame");
        end

        print_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- mandel_top.f
+incdir+sim
logic/mandel_pkg.sv
logic/mandel_alu.sv
logic/mandel_engine.sv
logic/mandel_config.sv
logic/pixel_credit_out.sv
logic/mandel_top.sv
sim/mandel_tb.sv

//--- Bender.yml
package:
  name: mandel_top

sources:
  - files:
      - logic/mandel_pkg.sv
      - logic/mandel_alu.sv
      - logic/mandel_engine.sv
      - logic/mandel_config.sv
      - logic/pixel_credit_out.sv
      - logic/mandel_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/mandel_tb.sv
